// File: rtl/burst_split_pkg.sv
package burst_split_pkg;

  // ------------------------------------------------------------------
  // Bus widths and queue depth
  // ------------------------------------------------------------------
  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned DATA_W   = 32;
  localparam int unsigned STRB_W   = DATA_W / 8;
  localparam int unsigned ID_W     = 4;
  localparam int unsigned LEN_W    = 8;
  localparam int unsigned SIZE_W   = 3;
  localparam int unsigned MAX_TXNS = 4;
  localparam int unsigned PTR_W    = $clog2(MAX_TXNS);

  // ------------------------------------------------------------------
  // Payload types
  // ------------------------------------------------------------------
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [ID_W-1:0]   id_t;
  typedef logic [LEN_W-1:0]  len_t;
  typedef logic [SIZE_W-1:0] size_t;
  // One bit wider than len so that len+1 always fits
  typedef logic [LEN_W:0]    beats_t;
  typedef logic [PTR_W-1:0]  ptr_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  // FSM states
  typedef enum logic {
    AX_IDLE,
    AX_BUSY
  } ax_state_e;

  typedef enum logic {
    B_PASS,
    B_HOLD
  } b_state_e;

endpackage

// File: rtl/aw_splitter.sv
`timescale 1ns/1ps

module aw_splitter (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  burst_split_pkg::len_t   len_limit_i,
  input  burst_split_pkg::id_t    s_aw_id_i,
  input  burst_split_pkg::addr_t  s_aw_addr_i,
  input  burst_split_pkg::len_t   s_aw_len_i,
  input  burst_split_pkg::size_t  s_aw_size_i,
  input  burst_split_pkg::burst_e s_aw_burst_i,
  input  logic                    s_aw_valid_i,
  output logic                    s_aw_ready_o,
  output burst_split_pkg::id_t    m_aw_id_o,
  output burst_split_pkg::addr_t  m_aw_addr_o,
  output burst_split_pkg::len_t   m_aw_len_o,
  output burst_split_pkg::size_t  m_aw_size_o,
  output burst_split_pkg::burst_e m_aw_burst_o,
  output logic                    m_aw_valid_o,
  input  logic                    m_aw_ready_i,
  input  logic                    alloc_ready_i,
  output logic                    alloc_req_o,
  output burst_split_pkg::len_t   alloc_len_o
);

  burst_split_pkg::ax_state_e state_d, state_q;
  burst_split_pkg::beats_t    beats_d, beats_q;
  burst_split_pkg::beats_t    max_beats;
  burst_split_pkg::addr_t     addr_d, addr_q;
  burst_split_pkg::id_t       id_q;
  burst_split_pkg::size_t     size_q;
  burst_split_pkg::burst_e    burst_q;
  logic                       load;
  logic                       last_sub;

  // Align to the beat size, then skip one full sub-burst
  function automatic burst_split_pkg::addr_t step_addr(
    input burst_split_pkg::addr_t  addr,
    input burst_split_pkg::size_t  size,
    input burst_split_pkg::beats_t step
  );
    burst_split_pkg::addr_t aligned;
    aligned = (addr >> size) << size;
    return aligned + (burst_split_pkg::addr_t'(step) << size);
  endfunction

  assign max_beats   = burst_split_pkg::beats_t'(len_limit_i) + 9'd1;
  assign last_sub    = (beats_q <= max_beats);
  assign alloc_len_o = s_aw_len_i;

  always_comb begin
    state_d      = state_q;
    beats_d      = beats_q;
    addr_d       = addr_q;
    load         = 1'b0;
    s_aw_ready_o = 1'b0;
    alloc_req_o  = 1'b0;
    m_aw_valid_o = 1'b0;
    m_aw_id_o    = s_aw_id_i;
    m_aw_addr_o  = s_aw_addr_i;
    m_aw_len_o   = s_aw_len_i;
    m_aw_size_o  = s_aw_size_i;
    m_aw_burst_o = s_aw_burst_i;
    case (state_q)
      burst_split_pkg::AX_IDLE: begin
        if (s_aw_valid_i && alloc_ready_i) begin
          m_aw_valid_o = 1'b1;
          if (s_aw_len_i <= len_limit_i) begin
            // Short enough, pass through untouched
            if (m_aw_ready_i) begin
              s_aw_ready_o = 1'b1;
              alloc_req_o  = 1'b1;
            end
          end else begin
            // Take the burst now and offer the first piece at once
            s_aw_ready_o = 1'b1;
            alloc_req_o  = 1'b1;
            load         = 1'b1;
            m_aw_len_o   = len_limit_i;
            state_d      = burst_split_pkg::AX_BUSY;
            beats_d      = burst_split_pkg::beats_t'(s_aw_len_i) + 9'd1;
            addr_d       = s_aw_addr_i;
            if (m_aw_ready_i) begin
              beats_d = beats_d - max_beats;
              if (s_aw_burst_i == burst_split_pkg::BURST_INCR) begin
                addr_d = step_addr(s_aw_addr_i, s_aw_size_i, max_beats);
              end
            end
          end
        end
      end
      burst_split_pkg::AX_BUSY: begin
        m_aw_valid_o = 1'b1;
        m_aw_id_o    = id_q;
        m_aw_addr_o  = addr_q;
        m_aw_size_o  = size_q;
        m_aw_burst_o = burst_q;
        // Last piece carries the remainder
        m_aw_len_o   = last_sub ? burst_split_pkg::len_t'(beats_q - 9'd1) : len_limit_i;
        if (m_aw_ready_i) begin
          if (last_sub) begin
            state_d = burst_split_pkg::AX_IDLE;
          end else begin
            beats_d = beats_q - max_beats;
            if (burst_q == burst_split_pkg::BURST_INCR) begin
              addr_d = step_addr(addr_q, size_q, max_beats);
            end
          end
        end
      end
      default: begin
        state_d = burst_split_pkg::AX_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= burst_split_pkg::AX_IDLE;
      beats_q <= '0;
    end else begin
      state_q <= state_d;
      beats_q <= beats_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    if (load) begin
      id_q    <= s_aw_id_i;
      size_q  <= s_aw_size_i;
      burst_q <= s_aw_burst_i;
    end
  end

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------
  // WRAP bursts are not supported upstream
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    s_aw_valid_i |-> s_aw_burst_i != burst_split_pkg::BURST_WRAP)
    else $error("WRAP burst received on AW");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_aw_valid_o |-> m_aw_len_o <= len_limit_i)
    else $error("Sub-burst longer than the length limit");

endmodule

// File: rtl/burst_tracker.sv
`timescale 1ns/1ps

module burst_tracker (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  burst_split_pkg::len_t len_limit_i,
  input  logic                  alloc_req_i,
  input  burst_split_pkg::len_t alloc_len_i,
  output logic                  alloc_ready_o,
  input  logic                  head_dec_i,
  input  logic                  head_err_set_i,
  output logic                  head_valid_o,
  output logic                  head_last_o,
  output logic                  head_err_o
);

  // Remaining beats per outstanding burst
  burst_split_pkg::beats_t cnt_q [burst_split_pkg::MAX_TXNS];

  burst_split_pkg::ptr_t          wr_ptr_q, rd_ptr_q;
  logic [burst_split_pkg::PTR_W:0] count_q;
  logic                            err_q;
  burst_split_pkg::beats_t         delta;
  logic                            push;
  logic                            pop;

  assign delta         = burst_split_pkg::beats_t'(len_limit_i) + 9'd1;
  assign alloc_ready_o = (count_q != burst_split_pkg::MAX_TXNS);
  assign head_valid_o  = (count_q != '0);
  assign head_last_o   = (cnt_q[rd_ptr_q] <= delta);
  // Current response counts as well as earlier ones
  assign head_err_o    = err_q | head_err_set_i;

  assign push = alloc_req_i & alloc_ready_o;
  assign pop  = head_dec_i & head_last_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      err_q    <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // Sticky flag belongs to the head only
      if (pop) begin
        err_q <= 1'b0;
      end else if (head_dec_i) begin
        err_q <= err_q | head_err_set_i;
      end
    end
  end

  // Push and decrement never hit the same entry
  always_ff @(posedge clk_i) begin
    if (push) begin
      cnt_q[wr_ptr_q] <= burst_split_pkg::beats_t'(alloc_len_i) + 9'd1;
    end
    if (head_dec_i && !head_last_o) begin
      cnt_q[rd_ptr_q] <= cnt_q[rd_ptr_q] - delta;
    end
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    head_dec_i |-> head_valid_o)
    else $error("B response with no outstanding burst");

endmodule

// File: rtl/w_last_gen.sv
`timescale 1ns/1ps

module w_last_gen (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  burst_split_pkg::len_t  len_limit_i,
  input  burst_split_pkg::data_t s_w_data_i,
  input  burst_split_pkg::strb_t s_w_strb_i,
  input  logic                   s_w_last_i,
  input  logic                   s_w_valid_i,
  output logic                   s_w_ready_o,
  output burst_split_pkg::data_t m_w_data_o,
  output burst_split_pkg::strb_t m_w_strb_o,
  output logic                   m_w_last_o,
  output logic                   m_w_valid_o,
  input  logic                   m_w_ready_i
);

  burst_split_pkg::len_t cnt_q;
  logic                  vld_q;
  logic                  beat;
  logic                  boundary;

  assign m_w_data_o  = s_w_data_i;
  assign m_w_strb_o  = s_w_strb_i;
  assign m_w_valid_o = s_w_valid_i;
  assign s_w_ready_o = m_w_ready_i;

  assign beat = s_w_valid_i & m_w_ready_i;

  // Counter hits zero on the final beat of a sub-burst
  assign boundary = vld_q & (cnt_q == '0);

  // Limit 0 is legacy mode, every beat closes a burst
  assign m_w_last_o = (len_limit_i == '0) | s_w_last_i | boundary;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
      vld_q <= 1'b0;
    end else if (beat && len_limit_i != '0) begin
      if (s_w_last_i) begin
        vld_q <= 1'b0;
        cnt_q <= '0;
      end else if (!vld_q) begin
        // First beat of an upstream burst
        vld_q <= 1'b1;
        cnt_q <= len_limit_i - 8'd1;
      end else if (boundary) begin
        cnt_q <= len_limit_i;
      end else begin
        cnt_q <= cnt_q - 8'd1;
      end
    end
  end

endmodule

// File: rtl/b_merger.sv
`timescale 1ns/1ps

module b_merger (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  burst_split_pkg::id_t  m_b_id_i,
  input  burst_split_pkg::resp_e m_b_resp_i,
  input  logic                  m_b_valid_i,
  output logic                  m_b_ready_o,
  output burst_split_pkg::id_t  s_b_id_o,
  output burst_split_pkg::resp_e s_b_resp_o,
  output logic                  s_b_valid_o,
  input  logic                  s_b_ready_i,
  input  logic                  head_valid_i,
  input  logic                  head_last_i,
  input  logic                  head_err_i,
  output logic                  head_dec_o,
  output logic                  head_err_set_o
);

  burst_split_pkg::b_state_e state_d, state_q;
  logic                      err_d, err_q;
  logic                      resp_err;

  // SLVERR and DECERR both have bit 1 set
  assign resp_err = (m_b_resp_i == burst_split_pkg::RESP_SLVERR) ||
                    (m_b_resp_i == burst_split_pkg::RESP_DECERR);

  assign s_b_id_o       = m_b_id_i;
  assign head_err_set_o = head_dec_o & resp_err;

  always_comb begin
    state_d     = state_q;
    err_d       = err_q;
    m_b_ready_o = 1'b0;
    s_b_valid_o = 1'b0;
    s_b_resp_o  = m_b_resp_i;
    head_dec_o  = 1'b0;
    case (state_q)
      burst_split_pkg::B_PASS: begin
        if (m_b_valid_i && head_valid_i) begin
          head_dec_o = 1'b1;
          if (head_last_i) begin
            s_b_valid_o = 1'b1;
            if (head_err_i) begin
              s_b_resp_o = burst_split_pkg::RESP_SLVERR;
            end
            if (s_b_ready_i) begin
              m_b_ready_o = 1'b1;
            end else begin
              // Tracker already popped, keep the merged error here
              state_d = burst_split_pkg::B_HOLD;
              err_d   = head_err_i;
            end
          end else begin
            // Intermediate response, swallow it
            m_b_ready_o = 1'b1;
          end
        end
      end
      burst_split_pkg::B_HOLD: begin
        s_b_valid_o = 1'b1;
        if (err_q) begin
          s_b_resp_o = burst_split_pkg::RESP_SLVERR;
        end
        if (m_b_valid_i && s_b_ready_i) begin
          m_b_ready_o = 1'b1;
          state_d     = burst_split_pkg::B_PASS;
        end
      end
      default: begin
        state_d = burst_split_pkg::B_PASS;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= burst_split_pkg::B_PASS;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      err_q   <= err_d;
    end
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    s_b_valid_o && !s_b_ready_i |=> s_b_valid_o && $stable(s_b_id_o) && $stable(s_b_resp_o))
    else $error("Upstream B dropped or changed before it was accepted");

endmodule

// File: rtl/burst_splitter_top.sv
`timescale 1ns/1ps

module burst_splitter_top (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  burst_split_pkg::len_t   len_limit_i,
  // Upstream
  input  burst_split_pkg::id_t    s_aw_id_i,
  input  burst_split_pkg::addr_t  s_aw_addr_i,
  input  burst_split_pkg::len_t   s_aw_len_i,
  input  burst_split_pkg::size_t  s_aw_size_i,
  input  burst_split_pkg::burst_e s_aw_burst_i,
  input  logic                    s_aw_valid_i,
  output logic                    s_aw_ready_o,
  input  burst_split_pkg::data_t  s_w_data_i,
  input  burst_split_pkg::strb_t  s_w_strb_i,
  input  logic                    s_w_last_i,
  input  logic                    s_w_valid_i,
  output logic                    s_w_ready_o,
  output burst_split_pkg::id_t    s_b_id_o,
  output burst_split_pkg::resp_e  s_b_resp_o,
  output logic                    s_b_valid_o,
  input  logic                    s_b_ready_i,
  // Downstream
  output burst_split_pkg::id_t    m_aw_id_o,
  output burst_split_pkg::addr_t  m_aw_addr_o,
  output burst_split_pkg::len_t   m_aw_len_o,
  output burst_split_pkg::size_t  m_aw_size_o,
  output burst_split_pkg::burst_e m_aw_burst_o,
  output logic                    m_aw_valid_o,
  input  logic                    m_aw_ready_i,
  output burst_split_pkg::data_t  m_w_data_o,
  output burst_split_pkg::strb_t  m_w_strb_o,
  output logic                    m_w_last_o,
  output logic                    m_w_valid_o,
  input  logic                    m_w_ready_i,
  input  burst_split_pkg::id_t    m_b_id_i,
  input  burst_split_pkg::resp_e  m_b_resp_i,
  input  logic                    m_b_valid_i,
  output logic                    m_b_ready_o
);

  logic                  alloc_req;
  logic                  alloc_ready;
  burst_split_pkg::len_t alloc_len;
  logic                  head_valid;
  logic                  head_last;
  logic                  head_err;
  logic                  head_dec;
  logic                  head_err_set;

  aw_splitter u_aw_splitter (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .len_limit_i   (len_limit_i),
    .s_aw_id_i     (s_aw_id_i),
    .s_aw_addr_i   (s_aw_addr_i),
    .s_aw_len_i    (s_aw_len_i),
    .s_aw_size_i   (s_aw_size_i),
    .s_aw_burst_i  (s_aw_burst_i),
    .s_aw_valid_i  (s_aw_valid_i),
    .s_aw_ready_o  (s_aw_ready_o),
    .m_aw_id_o     (m_aw_id_o),
    .m_aw_addr_o   (m_aw_addr_o),
    .m_aw_len_o    (m_aw_len_o),
    .m_aw_size_o   (m_aw_size_o),
    .m_aw_burst_o  (m_aw_burst_o),
    .m_aw_valid_o  (m_aw_valid_o),
    .m_aw_ready_i  (m_aw_ready_i),
    .alloc_ready_i (alloc_ready),
    .alloc_req_o   (alloc_req),
    .alloc_len_o   (alloc_len)
  );

  burst_tracker u_burst_tracker (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .len_limit_i    (len_limit_i),
    .alloc_req_i    (alloc_req),
    .alloc_len_i    (alloc_len),
    .alloc_ready_o  (alloc_ready),
    .head_dec_i     (head_dec),
    .head_err_set_i (head_err_set),
    .head_valid_o   (head_valid),
    .head_last_o    (head_last),
    .head_err_o     (head_err)
  );

  w_last_gen u_w_last_gen (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .len_limit_i (len_limit_i),
    .s_w_data_i  (s_w_data_i),
    .s_w_strb_i  (s_w_strb_i),
    .s_w_last_i  (s_w_last_i),
    .s_w_valid_i (s_w_valid_i),
    .s_w_ready_o (s_w_ready_o),
    .m_w_data_o  (m_w_data_o),
    .m_w_strb_o  (m_w_strb_o),
    .m_w_last_o  (m_w_last_o),
    .m_w_valid_o (m_w_valid_o),
    .m_w_ready_i (m_w_ready_i)
  );

  b_merger u_b_merger (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .m_b_id_i       (m_b_id_i),
    .m_b_resp_i     (m_b_resp_i),
    .m_b_valid_i    (m_b_valid_i),
    .m_b_ready_o    (m_b_ready_o),
    .s_b_id_o       (s_b_id_o),
    .s_b_resp_o     (s_b_resp_o),
    .s_b_valid_o    (s_b_valid_o),
    .s_b_ready_i    (s_b_ready_i),
    .head_valid_i   (head_valid),
    .head_last_i    (head_last),
    .head_err_i     (head_err),
    .head_dec_o     (head_dec),
    .head_err_set_o (head_err_set)
  );

endmodule

// File: bench/axi_wr_slave_model.sv
`timescale 1ns/1ps

module axi_wr_slave_model (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  burst_split_pkg::id_t    aw_id_i,
  input  burst_split_pkg::addr_t  aw_addr_i,
  input  burst_split_pkg::len_t   aw_len_i,
  input  burst_split_pkg::size_t  aw_size_i,
  input  burst_split_pkg::burst_e aw_burst_i,
  input  logic                    aw_valid_i,
  output logic                    aw_ready_o,
  input  burst_split_pkg::data_t  w_data_i,
  input  burst_split_pkg::strb_t  w_strb_i,
  input  logic                    w_last_i,
  input  logic                    w_valid_i,
  output logic                    w_ready_o,
  output burst_split_pkg::id_t    b_id_o,
  output burst_split_pkg::resp_e  b_resp_o,
  output logic                    b_valid_o,
  input  logic                    b_ready_i,
  // One bit per downstream AW index, set means answer with SLVERR
  input  logic [63:0]             err_sel_i
);

  burst_split_pkg::addr_t  aw_addr_log  [256];
  burst_split_pkg::len_t   aw_len_log   [256];
  burst_split_pkg::id_t    aw_id_log    [256];
  burst_split_pkg::size_t  aw_size_log  [256];
  burst_split_pkg::burst_e aw_burst_log [256];
  burst_split_pkg::data_t  w_data_log   [256];
  burst_split_pkg::strb_t  w_strb_log   [256];
  logic                    w_last_log   [256];
  int                      aw_cnt;
  int                      w_cnt;
  int                      wlast_cnt;
  int                      b_cnt;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      aw_ready_o <= 1'b0;
      w_ready_o  <= 1'b0;
      b_valid_o  <= 1'b0;
      b_id_o     <= '0;
      b_resp_o   <= burst_split_pkg::RESP_OKAY;
      aw_cnt     <= 0;
      w_cnt      <= 0;
      wlast_cnt  <= 0;
      b_cnt      <= 0;
    end else begin
      // Random back-pressure, ready about three cycles in four
      aw_ready_o <= ($urandom % 4) != 0;
      w_ready_o  <= ($urandom % 4) != 0;
      if (aw_valid_i && aw_ready_o) begin
        aw_addr_log[aw_cnt % 256]  <= aw_addr_i;
        aw_len_log[aw_cnt % 256]   <= aw_len_i;
        aw_id_log[aw_cnt % 256]    <= aw_id_i;
        aw_size_log[aw_cnt % 256]  <= aw_size_i;
        aw_burst_log[aw_cnt % 256] <= aw_burst_i;
        aw_cnt                     <= aw_cnt + 1;
      end
      if (w_valid_i && w_ready_o) begin
        w_data_log[w_cnt % 256] <= w_data_i;
        w_strb_log[w_cnt % 256] <= w_strb_i;
        w_last_log[w_cnt % 256] <= w_last_i;
        w_cnt                   <= w_cnt + 1;
        if (w_last_i) begin
          wlast_cnt <= wlast_cnt + 1;
        end
      end
      // One B per AW, in order, once its data has arrived
      if (b_valid_o) begin
        if (b_ready_i) begin
          b_valid_o <= 1'b0;
          b_cnt     <= b_cnt + 1;
        end
      end else if (b_cnt < aw_cnt && b_cnt < wlast_cnt && ($urandom % 2) == 0) begin
        b_valid_o <= 1'b1;
        b_id_o    <= aw_id_log[b_cnt % 256];
        b_resp_o  <= err_sel_i[b_cnt % 64] ? burst_split_pkg::RESP_SLVERR
                                           : burst_split_pkg::RESP_OKAY;
      end
    end
  end

endmodule

// File: bench/tb_burst_splitter.sv
`timescale 1ns/1ps

module tb_burst_splitter;

  localparam int TIMEOUT = 2000;

  logic                    clk_i;
  logic                    arst_n_i;
  burst_split_pkg::len_t   len_limit_i;
  burst_split_pkg::id_t    s_aw_id_i;
  burst_split_pkg::addr_t  s_aw_addr_i;
  burst_split_pkg::len_t   s_aw_len_i;
  burst_split_pkg::size_t  s_aw_size_i;
  burst_split_pkg::burst_e s_aw_burst_i;
  logic                    s_aw_valid_i;
  logic                    s_aw_ready_o;
  burst_split_pkg::data_t  s_w_data_i;
  burst_split_pkg::strb_t  s_w_strb_i;
  logic                    s_w_last_i;
  logic                    s_w_valid_i;
  logic                    s_w_ready_o;
  burst_split_pkg::id_t    s_b_id_o;
  burst_split_pkg::resp_e  s_b_resp_o;
  logic                    s_b_valid_o;
  logic                    s_b_ready_i;
  burst_split_pkg::id_t    m_aw_id_o;
  burst_split_pkg::addr_t  m_aw_addr_o;
  burst_split_pkg::len_t   m_aw_len_o;
  burst_split_pkg::size_t  m_aw_size_o;
  burst_split_pkg::burst_e m_aw_burst_o;
  logic                    m_aw_valid_o;
  logic                    m_aw_ready_i;
  burst_split_pkg::data_t  m_w_data_o;
  burst_split_pkg::strb_t  m_w_strb_o;
  logic                    m_w_last_o;
  logic                    m_w_valid_o;
  logic                    m_w_ready_i;
  burst_split_pkg::id_t    m_b_id_i;
  burst_split_pkg::resp_e  m_b_resp_i;
  logic                    m_b_valid_i;
  logic                    m_b_ready_o;
  logic [63:0]             err_sel;

  // Reference model state
  burst_split_pkg::addr_t exp_addr [64];
  burst_split_pkg::len_t  exp_len  [64];
  int                     exp_n;
  burst_split_pkg::data_t sent_data [256];
  burst_split_pkg::strb_t sent_strb [256];
  int                     sent_n;
  int                     seed_val;

  burst_splitter_top u_dut (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .len_limit_i  (len_limit_i),
    .s_aw_id_i    (s_aw_id_i),
    .s_aw_addr_i  (s_aw_addr_i),
    .s_aw_len_i   (s_aw_len_i),
    .s_aw_size_i  (s_aw_size_i),
    .s_aw_burst_i (s_aw_burst_i),
    .s_aw_valid_i (s_aw_valid_i),
    .s_aw_ready_o (s_aw_ready_o),
    .s_w_data_i   (s_w_data_i),
    .s_w_strb_i   (s_w_strb_i),
    .s_w_last_i   (s_w_last_i),
    .s_w_valid_i  (s_w_valid_i),
    .s_w_ready_o  (s_w_ready_o),
    .s_b_id_o     (s_b_id_o),
    .s_b_resp_o   (s_b_resp_o),
    .s_b_valid_o  (s_b_valid_o),
    .s_b_ready_i  (s_b_ready_i),
    .m_aw_id_o    (m_aw_id_o),
    .m_aw_addr_o  (m_aw_addr_o),
    .m_aw_len_o   (m_aw_len_o),
    .m_aw_size_o  (m_aw_size_o),
    .m_aw_burst_o (m_aw_burst_o),
    .m_aw_valid_o (m_aw_valid_o),
    .m_aw_ready_i (m_aw_ready_i),
    .m_w_data_o   (m_w_data_o),
    .m_w_strb_o   (m_w_strb_o),
    .m_w_last_o   (m_w_last_o),
    .m_w_valid_o  (m_w_valid_o),
    .m_w_ready_i  (m_w_ready_i),
    .m_b_id_i     (m_b_id_i),
    .m_b_resp_i   (m_b_resp_i),
    .m_b_valid_i  (m_b_valid_i),
    .m_b_ready_o  (m_b_ready_o)
  );

  axi_wr_slave_model u_slave (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .aw_id_i    (m_aw_id_o),
    .aw_addr_i  (m_aw_addr_o),
    .aw_len_i   (m_aw_len_o),
    .aw_size_i  (m_aw_size_o),
    .aw_burst_i (m_aw_burst_o),
    .aw_valid_i (m_aw_valid_o),
    .aw_ready_o (m_aw_ready_i),
    .w_data_i   (m_w_data_o),
    .w_strb_i   (m_w_strb_o),
    .w_last_i   (m_w_last_o),
    .w_valid_i  (m_w_valid_o),
    .w_ready_o  (m_w_ready_i),
    .b_id_o     (m_b_id_i),
    .b_resp_o   (m_b_resp_i),
    .b_valid_o  (m_b_valid_i),
    .b_ready_i  (m_b_ready_o),
    .err_sel_i  (err_sel)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------------
  // Checking helpers
  // ------------------------------------------------------------------
  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timed out waiting for %s", what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  // Sub-bursts of at most limit+1 beats, INCR steps from the aligned address
  task automatic build_expected(input burst_split_pkg::addr_t addr, input int len,
                                input int size, input burst_split_pkg::burst_e burst,
                                input int limit);
    int                     beats;
    int                     n;
    burst_split_pkg::addr_t a;
    burst_split_pkg::addr_t mask;
    beats = len + 1;
    a     = addr;
    mask  = (32'd1 << size) - 32'd1;
    exp_n = 0;
    while (beats > 0) begin
      n = (beats > limit + 1) ? limit + 1 : beats;
      exp_addr[exp_n] = a;
      exp_len[exp_n]  = burst_split_pkg::len_t'(n - 1);
      exp_n           = exp_n + 1;
      beats           = beats - n;
      if (burst == burst_split_pkg::BURST_INCR) begin
        a = (a & ~mask) + (burst_split_pkg::addr_t'(n) << size);
      end
    end
  endtask

  // ------------------------------------------------------------------
  // Upstream drivers
  // ------------------------------------------------------------------
  task automatic send_burst(input burst_split_pkg::id_t id, input burst_split_pkg::addr_t addr,
                            input int len, input int size, input burst_split_pkg::burst_e burst);
    int                     t;
    int                     i;
    burst_split_pkg::data_t d;
    burst_split_pkg::strb_t s;
    @(posedge clk_i);
    s_aw_id_i    <= id;
    s_aw_addr_i  <= addr;
    s_aw_len_i   <= burst_split_pkg::len_t'(len);
    s_aw_size_i  <= burst_split_pkg::size_t'(size);
    s_aw_burst_i <= burst;
    s_aw_valid_i <= 1'b1;
    t = 0;
    @(negedge clk_i);
    while (!s_aw_ready_o) begin
      t = t + 1;
      if (t > TIMEOUT) timeout_fail("upstream AW ready");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    s_aw_valid_i <= 1'b0;
    for (i = 0; i <= len; i++) begin
      d = $urandom;
      s = burst_split_pkg::strb_t'($urandom);
      sent_data[sent_n % 256] = d;
      sent_strb[sent_n % 256] = s;
      sent_n = sent_n + 1;
      s_w_data_i  <= d;
      s_w_strb_i  <= s;
      s_w_last_i  <= (i == len);
      s_w_valid_i <= 1'b1;
      t = 0;
      @(negedge clk_i);
      while (!s_w_ready_o) begin
        t = t + 1;
        if (t > TIMEOUT) timeout_fail("upstream W ready");
        @(negedge clk_i);
      end
      @(posedge clk_i);
    end
    s_w_valid_i <= 1'b0;
    s_w_last_i  <= 1'b0;
  endtask

  // Hold ready low for some cycles once B shows up, or toggle it at random
  task automatic expect_b(input burst_split_pkg::id_t id, input burst_split_pkg::resp_e resp,
                          input int hold, input bit rnd);
    int t;
    t = 0;
    @(negedge clk_i);
    while (!s_b_valid_o) begin
      t = t + 1;
      if (t > TIMEOUT) timeout_fail("upstream B valid");
      @(negedge clk_i);
    end
    repeat (hold) begin
      @(negedge clk_i);
      check_eq("s_b_valid_o", s_b_valid_o, 1);
    end
    t = 0;
    @(posedge clk_i);
    s_b_ready_i <= rnd ? 1'($urandom % 2) : 1'b1;
    @(negedge clk_i);
    while (!(s_b_ready_i && s_b_valid_o)) begin
      t = t + 1;
      if (t > TIMEOUT) timeout_fail("upstream B handshake");
      @(posedge clk_i);
      s_b_ready_i <= rnd ? 1'($urandom % 2) : 1'b1;
      @(negedge clk_i);
    end
    check_eq("s_b_id_o", s_b_id_o, id);
    check_eq("s_b_resp_o", s_b_resp_o, resp);
    @(posedge clk_i);
    s_b_ready_i <= 1'b0;
  endtask

  task automatic check_downstream(input int aw_base, input int w_base,
                                  input burst_split_pkg::id_t id, input int size,
                                  input burst_split_pkg::burst_e burst, input int len,
                                  input int limit);
    int   k;
    int   i;
    logic last;
    check_eq("m_aw count", u_slave.aw_cnt - aw_base, exp_n);
    for (k = 0; k < exp_n; k++) begin
      check_eq("m_aw_addr_o", u_slave.aw_addr_log[(aw_base + k) % 256], exp_addr[k]);
      check_eq("m_aw_len_o", u_slave.aw_len_log[(aw_base + k) % 256], exp_len[k]);
      check_eq("m_aw_id_o", u_slave.aw_id_log[(aw_base + k) % 256], id);
      check_eq("m_aw_size_o", u_slave.aw_size_log[(aw_base + k) % 256], size);
      check_eq("m_aw_burst_o", u_slave.aw_burst_log[(aw_base + k) % 256], burst);
    end
    check_eq("m_w beat count", u_slave.w_cnt - w_base, len + 1);
    for (i = 0; i <= len; i++) begin
      last = ((i + 1) % (limit + 1) == 0) || (i == len);
      check_eq("m_w_last_o", u_slave.w_last_log[(w_base + i) % 256], last);
      check_eq("m_w_data_o", u_slave.w_data_log[(w_base + i) % 256],
               sent_data[(w_base + i) % 256]);
      check_eq("m_w_strb_o", u_slave.w_strb_log[(w_base + i) % 256],
               sent_strb[(w_base + i) % 256]);
    end
  endtask

  // ------------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------------
  task automatic run_case(input burst_split_pkg::id_t id, input burst_split_pkg::addr_t addr,
                          input int len, input int size, input burst_split_pkg::burst_e burst,
                          input int limit, input int err_sub, input int hold);
    int                     aw_base;
    int                     w_base;
    burst_split_pkg::resp_e exp_resp;
    @(posedge clk_i);
    len_limit_i <= burst_split_pkg::len_t'(limit);
    aw_base  = u_slave.aw_cnt;
    w_base   = sent_n;
    exp_resp = burst_split_pkg::RESP_OKAY;
    build_expected(addr, len, size, burst, limit);
    if (err_sub >= 0) begin
      err_sel[(aw_base + err_sub) % 64] = 1'b1;
      exp_resp = burst_split_pkg::RESP_SLVERR;
    end
    send_burst(id, addr, len, size, burst);
    expect_b(id, exp_resp, hold, 1'b0);
    check_downstream(aw_base, w_base, id, size, burst, len, limit);
  endtask

  task automatic run_outstanding();
    int                     lens [4];
    int                     errs [4];
    burst_split_pkg::resp_e exp_resp [4];
    int                     aw_base;
    int                     total;
    int                     b;
    lens[0] = 5;
    lens[1] = 2;
    lens[2] = 9;
    lens[3] = 0;
    errs[0] = -1;
    errs[1] = 0;
    errs[2] = 2;
    errs[3] = -1;
    @(posedge clk_i);
    len_limit_i <= 8'd3;
    aw_base = u_slave.aw_cnt;
    total   = 0;
    for (b = 0; b < burst_split_pkg::MAX_TXNS; b++) begin
      build_expected(32'h4000 + b * 32'h100, lens[b], 2, burst_split_pkg::BURST_INCR, 3);
      exp_resp[b] = burst_split_pkg::RESP_OKAY;
      if (errs[b] >= 0) begin
        err_sel[(aw_base + total + errs[b]) % 64] = 1'b1;
        exp_resp[b] = burst_split_pkg::RESP_SLVERR;
      end
      total = total + exp_n;
    end
    for (b = 0; b < burst_split_pkg::MAX_TXNS; b++) begin
      send_burst(burst_split_pkg::id_t'(b + 8), 32'h4000 + b * 32'h100, lens[b], 2,
                 burst_split_pkg::BURST_INCR);
    end
    for (b = 0; b < burst_split_pkg::MAX_TXNS; b++) begin
      expect_b(burst_split_pkg::id_t'(b + 8), exp_resp[b], 0, 1'b1);
    end
    check_eq("m_aw count", u_slave.aw_cnt - aw_base, total);
  endtask

  initial begin
    arst_n_i     = 1'b0;
    len_limit_i  = '0;
    s_aw_id_i    = '0;
    s_aw_addr_i  = '0;
    s_aw_len_i   = '0;
    s_aw_size_i  = '0;
    s_aw_burst_i = burst_split_pkg::BURST_INCR;
    s_aw_valid_i = 1'b0;
    s_w_data_i   = '0;
    s_w_strb_i   = '1;
    s_w_last_i   = 1'b0;
    s_w_valid_i  = 1'b0;
    s_b_ready_i  = 1'b0;
    err_sel      = '0;
    sent_n       = 0;
    seed_val     = $urandom(32'h7d68);
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);

    // Feed-through, INCR split, FIXED split, legacy mode
    run_case(4'h1, 32'h1000, 2, 2, burst_split_pkg::BURST_INCR, 3, -1, 0);
    run_case(4'h2, 32'h2006, 9, 2, burst_split_pkg::BURST_INCR, 3, -1, 0);
    run_case(4'h3, 32'h3000, 7, 2, burst_split_pkg::BURST_FIXED, 1, -1, 0);
    run_case(4'h4, 32'h3800, 3, 2, burst_split_pkg::BURST_INCR, 0, -1, 0);
    // Error on the middle sub-burst, with and without upstream stall
    run_case(4'h5, 32'h5000, 9, 2, burst_split_pkg::BURST_INCR, 3, 1, 0);
    run_case(4'h6, 32'h6004, 9, 2, burst_split_pkg::BURST_INCR, 3, 1, 6);
    run_outstanding();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: verilog.f
rtl/burst_split_pkg.sv
rtl/aw_splitter.sv
rtl/burst_tracker.sv
rtl/w_last_gen.sv
rtl/b_merger.sv
rtl/burst_splitter_top.sv
bench/axi_wr_slave_model.sv
bench/tb_burst_splitter.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_burst_splitter -f verilog.f -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
  exit 0
else
  exit 1
fi
